/* all.f */
hdl/llc_pkg.sv
hdl/cacheline_adaptor.sv
hdl/line_cache.sv
hdl/llc_top.sv
dv/burst_mem_model.sv
dv/llc_top_chk.sv
dv/tb_llc_top.sv

/* Makefile */
TOP = tb_llc_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1; cat sim.log
	grep -qx '\*\* PASS \*\*' sim.log

lint:
	verilator --lint-only -Wall --top-module llc_top \
		hdl/llc_pkg.sv hdl/cacheline_adaptor.sv hdl/line_cache.sv hdl/llc_top.sv

clean:
	rm -rf obj_dir sim.log

/* dv/tb_llc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_llc_top;

    localparam int TIMEOUT = 300; // cycles per wait
    localparam int WORDS   = 512; // shadowed 2 KB window

    logic              clk = 1'b0;
    logic              reset_n = 1'b0;
    logic              cpu_valid = 1'b0;
    llc_pkg::cpu_req_t cpu_req = '0;
    logic              cpu_ready;
    llc_pkg::cpu_rsp_t cpu_rsp;
    logic [63:0]       mem_rdata;
    logic              mem_resp;
    logic [31:0]       mem_addr;
    logic [63:0]       mem_wdata;
    logic              mem_read;
    logic              mem_write;

    logic [31:0] shadow [WORDS];   // expected memory image
    logic [32:0] exp_q [$];        // {load, word} per accepted request
    logic [32:0] exp_item;
    logic        burst_kind [$];   // 1 for a write burst
    logic [31:0] burst_addr [$];
    logic [63:0] wr_beats [$];     // write data seen at the memory port
    int          rd_beats;
    logic        prev_req = 1'b0;
    integer      seed = 32'h3fdc_05a3;
    int          errors;
    int          checks;
    int          tests;
    int          lat;
    bit          hung;             // a wait ran out

    llc_top #(
        .NUM_LINES   (8)
    ) i_llc_top (
        .clk         (clk),
        .reset_n     (reset_n),
        .cpu_valid_i (cpu_valid),
        .cpu_req_i   (cpu_req),
        .cpu_ready_o (cpu_ready),
        .cpu_rsp_o   (cpu_rsp),
        .mem_rdata_i (mem_rdata),
        .mem_resp_i  (mem_resp),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_read_o  (mem_read),
        .mem_write_o (mem_write)
    );

    burst_mem_model #(
        .SEED        (32'h3fdc_05a3)
    ) i_burst_mem_model (
        .clk         (clk),
        .reset_n     (reset_n),
        .mem_addr_i  (mem_addr),
        .mem_wdata_i (mem_wdata),
        .mem_read_i  (mem_read),
        .mem_write_i (mem_write),
        .mem_rdata_o (mem_rdata),
        .mem_resp_o  (mem_resp)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] init_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f; // memory contents before any store
    endfunction

    function automatic logic [31:0] ref_read(input logic [31:0] addr);
        return shadow[addr[10:2]]; // last value stored, else initial word
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (hung) return;
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %0t %s got %h exp %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        $display("test %-12s %s", name, (errors == err_before && !hung) ? "ok" : "failed");
    endtask

    task automatic clear_traffic();
        burst_kind.delete();
        burst_addr.delete();
        wr_beats.delete();
        rd_beats = 0;
    endtask

    // one request, returns with lat set, called 1 ns after a rising edge
    task automatic access(input logic [31:0] addr, input logic we, input logic [31:0] wdata);
        int n;
        if (hung) return;
        cpu_valid = 1'b1;
        cpu_req   = '{addr: addr, we: we, wdata: wdata};
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!cpu_ready && n < TIMEOUT);
        if (!cpu_ready) begin
            $display("timeout, request to %h was never accepted", addr);
            hung = 1'b1;
            return;
        end
        if (we) shadow[addr[10:2]] = wdata;
        exp_q.push_back(we ? {1'b0, wdata} : {1'b1, ref_read(addr)});
        @(posedge clk); // accepted here
        #1;
        cpu_valid = 1'b0;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!cpu_rsp.valid && lat < TIMEOUT);
        if (!cpu_rsp.valid) begin
            $display("timeout, no response for the request to %h", addr);
            hung = 1'b1;
            return;
        end
        @(posedge clk);
        #1;
    endtask

    // response compare and memory port monitor, outputs stable at the falling edge
    always @(negedge clk) begin
        if (reset_n) begin
            if (cpu_rsp.valid) begin
                assert (exp_q.size() != 0) else begin
                    $display("response at %0t with no request in flight", $time);
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    exp_item = exp_q.pop_front();
                    if (exp_item[32]) compare_value("cpu_rsp_o.rdata", cpu_rsp.rdata, exp_item[31:0]);
                end
            end
            if ((mem_read || mem_write) && !prev_req) begin // new burst
                burst_kind.push_back(mem_write);
                burst_addr.push_back(mem_addr);
            end
            if (mem_write && mem_resp) wr_beats.push_back(mem_wdata);
            if (mem_read && mem_resp) rd_beats++;
            prev_req = mem_read || mem_write;
        end
    end

    initial begin
        logic [31:0] r;
        int          e0;
        for (int k = 0; k < WORDS; k++) shadow[k] = init_word(k * 4);
        repeat (3) @(posedge clk);
        #1;
        reset_n = 1'b1;

        e0 = errors;
        @(negedge clk);
        compare_value("cpu_ready_o", cpu_ready, 1);
        compare_value("mem_read_o", mem_read, 0);
        compare_value("mem_write_o", mem_write, 0);
        compare_value("cpu_rsp_o.valid", cpu_rsp.valid, 0);
        report_test("reset", e0);
        @(posedge clk);
        #1;

        e0 = errors;
        clear_traffic();
        access(32'h0000_0124, 1'b0, '0); // cold miss
        compare_value("burst count", burst_kind.size(), 1);
        compare_value("mem_write_o burst", burst_kind[0], 0);
        compare_value("mem_addr_o", burst_addr[0], 32'h120);
        compare_value("read beats", rd_beats, 4);
        clear_traffic();
        access(32'h0000_012c, 1'b0, '0); // same line
        compare_value("hit latency", lat, 2);
        compare_value("burst count", burst_kind.size(), 0);
        report_test("miss_hit", e0);

        e0 = errors;
        clear_traffic();
        access(32'h0000_0128, 1'b1, 32'hc001_d00d);
        compare_value("store latency", lat, 2);
        access(32'h0000_0128, 1'b0, '0);
        compare_value("burst count", burst_kind.size(), 0);
        report_test("store_load", e0);

        e0 = errors;
        clear_traffic();
        access(32'h0000_0224, 1'b0, '0); // index 1, new tag, evicts 0x120
        compare_value("burst count", burst_kind.size(), 2);
        compare_value("mem_write_o burst", burst_kind[0], 1);
        compare_value("victim mem_addr_o", burst_addr[0], 32'h120);
        compare_value("mem_write_o fill burst", burst_kind[1], 0);
        compare_value("fill mem_addr_o", burst_addr[1], 32'h220);
        compare_value("write beats", wr_beats.size(), 4);
        compare_value("read beats", rd_beats, 4);
        for (int k = 0; k < 4; k++) begin
            compare_value("mem_wdata_o", wr_beats[k],
                          {ref_read(32'h124 + 8 * k), ref_read(32'h120 + 8 * k)});
        end
        report_test("eviction", e0);

        e0 = errors;
        for (int k = 0; k < 200; k++) begin
            r = $random(seed);
            access({21'd0, r[10:2], 2'b00}, r[11], $random(seed));
        end
        for (int k = 0; k < 8; k++) begin
            access(32'(k * 32), 1'b0, '0);           // two tags per index
            access(32'(k * 32 + 32'h400), 1'b0, '0); // leaves clean lines only
        end
        for (int k = 0; k < WORDS / 2; k++) begin
            compare_value("memory beat", i_burst_mem_model.mem[k],
                          {shadow[2 * k + 1], shadow[2 * k]});
        end
        report_test("random_mix", e0);

        compare_value("bound assertion failures", i_llc_top.i_llc_top_chk.err_cnt, 0);
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (!hung && errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : tb_llc_top

`default_nettype wire

/* dv/llc_top_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module llc_top_chk (
    input wire clk,
    input wire reset_n,
    input wire mem_read_i,
    input wire mem_write_i,
    input wire mem_resp_i
);

    logic [1:0]  beat_cnt;     // beats of the open burst
    logic        last_beat;
    int unsigned err_cnt = 0;  // read back at the end of the run

    assign last_beat = mem_resp_i && (beat_cnt == 2'd3);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            beat_cnt <= '0;
        end else if (mem_resp_i && (mem_read_i || mem_write_i)) begin
            beat_cnt <= beat_cnt + 2'd1;
        end
    end

    a_one_dir: assert property (@(posedge clk) disable iff (!reset_n)
        !(mem_read_i && mem_write_i))
        else begin $error("read and write requested together"); err_cnt++; end
    a_read_held: assert property (@(posedge clk) disable iff (!reset_n)
        mem_read_i && !last_beat |=> mem_read_i)
        else begin $error("read request dropped before beat 4"); err_cnt++; end
    a_write_held: assert property (@(posedge clk) disable iff (!reset_n)
        mem_write_i && !last_beat |=> mem_write_i)
        else begin $error("write request dropped before beat 4"); err_cnt++; end
    a_drop: assert property (@(posedge clk) disable iff (!reset_n)
        last_beat |=> !(mem_read_i || mem_write_i))
        else begin $error("request held after beat 4"); err_cnt++; end
    a_beat_in_req: assert property (@(posedge clk) disable iff (!reset_n)
        mem_resp_i |-> (mem_read_i || mem_write_i))
        else begin $error("memory beat with no request"); err_cnt++; end

endmodule : llc_top_chk

bind llc_top llc_top_chk i_llc_top_chk (
    .clk         (clk),
    .reset_n     (reset_n),
    .mem_read_i  (mem_read_o),
    .mem_write_i (mem_write_o),
    .mem_resp_i  (mem_resp_i)
);

`default_nettype wire

/* dv/burst_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module burst_mem_model #(
    parameter int SEED = 1 // stall pattern
) (
    input  wire         clk,
    input  wire         reset_n,
    input  wire  [31:0] mem_addr_i,
    input  wire  [63:0] mem_wdata_i,
    input  wire         mem_read_i,
    input  wire         mem_write_i,
    output logic [63:0] mem_rdata_o = '0,
    output logic        mem_resp_o = 1'b0
);

    logic [63:0] mem [256];  // 2 KB window, higher bits ignored
    logic [1:0]  beat;       // position inside the burst
    integer      seed = SEED;

    function automatic logic [31:0] init_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f; // whole address mixed in
    endfunction

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = {init_word(i * 8 + 4), init_word(i * 8)}; // two words per beat
        end
    end

    // beat taken at the coming edge, stable here
    always @(negedge clk) begin
        if (!reset_n) begin
            beat <= '0;
        end else if (mem_resp_o) begin
            if (mem_write_i) begin
                mem[{mem_addr_i[10:5], beat}] <= mem_wdata_i;
            end
            beat <= beat + 2'd1; // wraps after beat 3
        end
    end

    always @(posedge clk) begin
        #1;
        if (reset_n && (mem_read_i || mem_write_i)) begin
            mem_resp_o  <= ($random(seed) & 3) != 0; // stall one cycle in four
            mem_rdata_o <= mem[{mem_addr_i[10:5], beat}];
        end else begin
            mem_resp_o  <= 1'b0;
            mem_rdata_o <= '0;
        end
    end

endmodule : burst_mem_model

`default_nettype wire

/* hdl/llc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module llc_top #(
    parameter int NUM_LINES = 8 // lines in the cache
) (
    input  wire                        clk,
    input  wire                        reset_n,

    // processor port
    input  wire                        cpu_valid_i,
    input  wire llc_pkg::cpu_req_t     cpu_req_i,
    output logic                       cpu_ready_o,
    output llc_pkg::cpu_rsp_t          cpu_rsp_o,

    // memory burst port
    input  wire [llc_pkg::BEAT_W-1:0]  mem_rdata_i,
    input  wire                        mem_resp_i,
    output logic [llc_pkg::ADDR_W-1:0] mem_addr_o,
    output logic [llc_pkg::BEAT_W-1:0] mem_wdata_o,
    output logic                       mem_read_o,
    output logic                       mem_write_o
);

    llc_pkg::line_req_t          line_req;   // cache to adaptor
    logic [llc_pkg::LINE_W-1:0]  line_rdata; // filled line
    logic                        line_done;  // burst finished

    line_cache #(
        .NUM_LINES    (NUM_LINES)
    ) i_line_cache (
        .clk          (clk),
        .reset_n      (reset_n),
        .cpu_valid_i  (cpu_valid_i),
        .cpu_req_i    (cpu_req_i),
        .cpu_ready_o  (cpu_ready_o),
        .cpu_rsp_o    (cpu_rsp_o),
        .line_rdata_i (line_rdata),
        .line_done_i  (line_done),
        .line_req_o   (line_req)
    );

    cacheline_adaptor i_cacheline_adaptor (
        .clk          (clk),
        .reset_n      (reset_n),
        .line_req_i   (line_req),
        .line_rdata_o (line_rdata),
        .line_done_o  (line_done),
        .mem_rdata_i  (mem_rdata_i),
        .mem_resp_i   (mem_resp_i),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_read_o   (mem_read_o),
        .mem_write_o  (mem_write_o)
    );

endmodule : llc_top

`default_nettype wire

/* hdl/line_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module line_cache #(
    parameter int NUM_LINES = 8 // power of two
) (
    input  wire                        clk,
    input  wire                        reset_n,

    // processor side
    input  wire                        cpu_valid_i,
    input  wire llc_pkg::cpu_req_t     cpu_req_i,
    output logic                       cpu_ready_o,
    output llc_pkg::cpu_rsp_t          cpu_rsp_o,

    // adaptor side
    input  wire [llc_pkg::LINE_W-1:0]  line_rdata_i,
    input  wire                        line_done_i,
    output llc_pkg::line_req_t         line_req_o
);

    localparam int OFFS_W  = $clog2(llc_pkg::LINE_W / 8);               // 5 byte offset bits
    localparam int INDEX_W = $clog2(NUM_LINES);
    localparam int TAG_W   = llc_pkg::ADDR_W - OFFS_W - INDEX_W;

    llc_pkg::cache_state_e       state_q;
    llc_pkg::cache_state_e       state_d;

    // line store
    logic [TAG_W-1:0]            tag_q  [NUM_LINES];
    logic [llc_pkg::LINE_W-1:0]  data_q [NUM_LINES];
    logic [NUM_LINES-1:0]        valid_q;
    logic [NUM_LINES-1:0]        dirty_q;

    llc_pkg::cpu_req_t           req_q;       // request in flight
    logic [llc_pkg::WORD_W-1:0]  rdata_q;     // response word

    logic [INDEX_W-1:0]          idx;
    logic [TAG_W-1:0]            req_tag;
    logic [2:0]                  word_sel;    // word within line
    logic                        hit;
    logic                        victim_dirty;
    logic [llc_pkg::LINE_W-1:0]  base_line;   // stored or filled line
    logic [llc_pkg::LINE_W-1:0]  merged_line; // with the store word
    logic [llc_pkg::WORD_W-1:0]  rsp_word;

    assign idx          = req_q.addr[OFFS_W +: INDEX_W];
    assign req_tag      = req_q.addr[llc_pkg::ADDR_W-1 -: TAG_W];
    assign word_sel     = req_q.addr[4:2];
    assign hit          = valid_q[idx] && (tag_q[idx] == req_tag);
    assign victim_dirty = valid_q[idx] && dirty_q[idx]; // only called on a miss

    always_comb begin
        if (state_q == llc_pkg::ST_FILL) begin
            base_line = line_rdata_i; // fresh from memory
        end else begin
            base_line = data_q[idx];
        end
        merged_line = base_line;
        if (req_q.we) begin
            merged_line[word_sel*llc_pkg::WORD_W +: llc_pkg::WORD_W] = req_q.wdata;
        end
    end

    assign rsp_word = merged_line[word_sel*llc_pkg::WORD_W +: llc_pkg::WORD_W];

    // miss controller
    always_comb begin
        state_d = state_q;
        case (state_q)
            llc_pkg::ST_IDLE: begin
                if (cpu_valid_i) begin
                    state_d = llc_pkg::ST_LOOKUP;
                end
            end
            llc_pkg::ST_LOOKUP: begin
                if (hit) begin
                    state_d = llc_pkg::ST_RESP;
                end else if (victim_dirty) begin
                    state_d = llc_pkg::ST_WRBACK; // evict first
                end else begin
                    state_d = llc_pkg::ST_FILL;
                end
            end
            llc_pkg::ST_WRBACK: begin
                if (line_done_i) begin
                    state_d = llc_pkg::ST_FILL;
                end
            end
            llc_pkg::ST_FILL: begin
                if (line_done_i) begin
                    state_d = llc_pkg::ST_RESP;
                end
            end
            llc_pkg::ST_RESP: begin
                state_d = llc_pkg::ST_IDLE;
            end
            default: begin
                state_d = llc_pkg::ST_IDLE;
            end
        endcase
    end

    // state and line status
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= llc_pkg::ST_IDLE;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == llc_pkg::ST_LOOKUP && hit && req_q.we) begin
                dirty_q[idx] <= 1'b1; // store hit
            end
            if (state_q == llc_pkg::ST_FILL && line_done_i) begin
                valid_q[idx] <= 1'b1;
                dirty_q[idx] <= req_q.we; // store miss merges at fill
            end
        end
    end

    // request, tags and data
    always_ff @(posedge clk) begin
        if (state_q == llc_pkg::ST_IDLE && cpu_valid_i) begin
            req_q <= cpu_req_i; // accept
        end
        if (state_q == llc_pkg::ST_LOOKUP && hit) begin
            rdata_q <= rsp_word;
            if (req_q.we) begin
                data_q[idx] <= merged_line;
            end
        end
        if (state_q == llc_pkg::ST_FILL && line_done_i) begin
            data_q[idx] <= merged_line;
            tag_q[idx]  <= req_tag;
            rdata_q     <= rsp_word;
        end
    end

    assign cpu_ready_o     = (state_q == llc_pkg::ST_IDLE);
    assign cpu_rsp_o.valid = (state_q == llc_pkg::ST_RESP);
    assign cpu_rsp_o.rdata = rdata_q;

    // held until line_done, new state picks the next request
    assign line_req_o.read  = (state_q == llc_pkg::ST_FILL);
    assign line_req_o.write = (state_q == llc_pkg::ST_WRBACK);
    assign line_req_o.addr  = (state_q == llc_pkg::ST_WRBACK)
                            ? {tag_q[idx], idx, {OFFS_W{1'b0}}} // victim address
                            : {req_tag, idx, {OFFS_W{1'b0}}};
    assign line_req_o.line  = data_q[idx];

endmodule : line_cache

`default_nettype wire

/* hdl/cacheline_adaptor.sv */
`timescale 1ns/1ps
`default_nettype none

module cacheline_adaptor (
    input  wire                        clk,
    input  wire                        reset_n,

    // cache side
    input  wire llc_pkg::line_req_t    line_req_i,
    output logic [llc_pkg::LINE_W-1:0] line_rdata_o,
    output logic                       line_done_o,

    // memory side
    input  wire [llc_pkg::BEAT_W-1:0]  mem_rdata_i,
    input  wire                        mem_resp_i,
    output logic [llc_pkg::ADDR_W-1:0] mem_addr_o,
    output logic [llc_pkg::BEAT_W-1:0] mem_wdata_o,
    output logic                       mem_read_o,
    output logic                       mem_write_o
);

    localparam int CNT_W = $clog2(llc_pkg::BEATS); // beat index width

    llc_pkg::adapt_mode_e        mode_q;    // burst direction
    logic [CNT_W-1:0]            cnt_q;     // current beat
    logic [llc_pkg::LINE_W-1:0]  line_q;    // assembled or latched line
    logic [llc_pkg::ADDR_W-1:0]  addr_q;    // burst address
    logic                        req_seen;  // cache asks for a burst
    logic                        last_beat; // fourth beat accepted

    assign req_seen  = line_req_i.read || line_req_i.write;
    assign last_beat = mem_resp_i && (cnt_q == CNT_W'(llc_pkg::BEATS - 1));

    // burst sequencing
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mode_q <= llc_pkg::MODE_IDLE;
            cnt_q  <= '0;
        end else begin
            case (mode_q)
                llc_pkg::MODE_IDLE: begin
                    cnt_q <= '0; // every burst starts at beat 0
                    if (line_req_i.read) begin
                        mode_q <= llc_pkg::MODE_LOAD;
                    end else if (line_req_i.write) begin
                        mode_q <= llc_pkg::MODE_STORE;
                    end
                end
                llc_pkg::MODE_LOAD,
                llc_pkg::MODE_STORE: begin
                    if (mem_resp_i) begin
                        cnt_q <= cnt_q + 1'b1; // low resp stalls here
                        if (last_beat) begin
                            mode_q <= llc_pkg::MODE_DONE;
                        end
                    end
                end
                llc_pkg::MODE_DONE: begin
                    mode_q <= llc_pkg::MODE_IDLE; // one cycle only
                end
                default: begin
                    mode_q <= llc_pkg::MODE_IDLE;
                end
            endcase
        end
    end

    // address and line data
    always_ff @(posedge clk) begin
        if (mode_q == llc_pkg::MODE_IDLE) begin
            if (req_seen) begin
                addr_q <= line_req_i.addr; // held for the whole burst
            end
            if (line_req_i.write) begin
                line_q <= line_req_i.line; // victim latched at start
            end
        end else if (mode_q == llc_pkg::MODE_LOAD && mem_resp_i) begin
            line_q[cnt_q*llc_pkg::BEAT_W +: llc_pkg::BEAT_W] <= mem_rdata_i; // ascending beats
        end
    end

    assign mem_read_o   = (mode_q == llc_pkg::MODE_LOAD);
    assign mem_write_o  = (mode_q == llc_pkg::MODE_STORE);
    assign mem_addr_o   = addr_q;
    assign mem_wdata_o  = line_q[cnt_q*llc_pkg::BEAT_W +: llc_pkg::BEAT_W]; // beat by counter
    assign line_rdata_o = line_q;
    assign line_done_o  = (mode_q == llc_pkg::MODE_DONE); // request drops here too

endmodule : cacheline_adaptor

`default_nettype wire

/* hdl/llc_pkg.sv */
`default_nettype none

package llc_pkg;

    localparam int ADDR_W = 32;  // byte address
    localparam int LINE_W = 256; // one cache line
    localparam int BEAT_W = 64;  // memory bus beat
    localparam int BEATS  = LINE_W / BEAT_W; // beats per line, 4
    localparam int WORD_W = 32;  // processor word

    // processor request, 65 bits
    typedef struct packed {
        logic [ADDR_W-1:0] addr;  // word aligned byte address
        logic              we;    // store when set
        logic [WORD_W-1:0] wdata; // store data
    } cpu_req_t;

    typedef struct packed {
        logic              valid; // one cycle pulse
        logic [WORD_W-1:0] rdata; // load data
    } cpu_rsp_t;

    // line request towards the adaptor
    typedef struct packed {
        logic              read;  // fill
        logic              write; // write back
        logic [ADDR_W-1:0] addr;  // line aligned
        logic [LINE_W-1:0] line;  // victim data
    } line_req_t;

    typedef enum logic [2:0] {
        ST_IDLE,   // ready for a request
        ST_LOOKUP, // tag compare
        ST_WRBACK, // dirty victim out
        ST_FILL,   // new line in
        ST_RESP    // answer the processor
    } cache_state_e;

    typedef enum logic [1:0] {
        MODE_IDLE,
        MODE_LOAD,  // memory to line
        MODE_STORE, // line to memory
        MODE_DONE   // done pulse
    } adapt_mode_e;

endpackage : llc_pkg

`default_nettype wire
